// ==== cube_macros.svh ====
// ##########################################################################
// cube renderer sizes, display timing, engine and edge counts
// ##########################################################################

`ifndef CUBE_MACROS_SVH
`define CUBE_MACROS_SVH

`define CORDW      16   // signed screen coordinate width

// framebuffer, same as the visible area
`define FB_WIDTH   160
`define FB_HEIGHT  120

// horizontal timing in pixels
`define H_FRONT    8
`define H_SYNC     16
`define H_BACK     16

// vertical timing in lines
`define V_FRONT    2
`define V_SYNC     2
`define V_BACK     4

`define CIDXW      4    // colour index
`define CHANW      4    // per colour channel

`define N_ENGINES  3    // line engines in the bank
`define LINE_CNT   9    // cube edges

`endif

// ==== cube_pkg.sv ====
// ##########################################################################
// cube renderer shared types: coordinates, colours, FSM states
// ##########################################################################

`default_nettype none

`include "cube_macros.svh"

package cube_pkg;

    typedef logic signed [`CORDW-1:0] coord_t;  // screen / fb position
    typedef logic [`CIDXW-1:0] cidx_t;          // palette index
    typedef logic [`CHANW-1:0] chan_t;          // one of r, g, b

    // edge dispatcher
    typedef enum logic [2:0] {
        IDLE,
        WAIT_FRAME,
        ISSUE,
        WAIT_DONE,
        FINISHED
    } dispatch_state_t;

    // Bresenham engine
    typedef enum logic [1:0] {
        L_IDLE,
        L_INIT,
        L_DRAW
    } line_state_t;

endpackage

`default_nettype wire

// ==== display_timings.sv ====
// ##########################################################################
// display timing generator: screen position, data enable, active high
// syncs and a single cycle frame start at 0,0
// ##########################################################################

`default_nettype none
`timescale 1ns/1ps

`include "cube_macros.svh"

module display_timings import cube_pkg::*; (
    input  wire logic clk_100m,
    input  wire logic rst,
    output coord_t    sx,      // horizontal position
    output coord_t    sy,      // vertical position
    output logic      de,      // visible area
    output logic      hsync,
    output logic      vsync,
    output logic      frame    // start of frame
);

    // active area first, then front porch, sync and back porch
    localparam int H_ACT        = `FB_WIDTH;
    localparam int H_SYNC_START = H_ACT + `H_FRONT;
    localparam int H_SYNC_END   = H_SYNC_START + `H_SYNC;
    localparam int H_TOTAL      = H_SYNC_END + `H_BACK;

    localparam int V_ACT        = `FB_HEIGHT;
    localparam int V_SYNC_START = V_ACT + `V_FRONT;
    localparam int V_SYNC_END   = V_SYNC_START + `V_SYNC;
    localparam int V_TOTAL      = V_SYNC_END + `V_BACK;

    // position counters
    always_ff @(posedge clk_100m) begin
        if (sx == H_TOTAL - 1) begin
            sx <= '0;
            if (sy == V_TOTAL - 1) begin
                sy <= '0;
            end else begin
                sy <= sy + 1'b1;  // next line
            end
        end else begin
            sx <= sx + 1'b1;
        end
        if (rst) begin
            sx <= '0;
            sy <= '0;
        end
    end

    always_comb begin
        de    = (sx < H_ACT) && (sy < V_ACT);
        hsync = (sx >= H_SYNC_START) && (sx < H_SYNC_END);
        vsync = (sy >= V_SYNC_START) && (sy < V_SYNC_END);
        frame = (sx == 0) && (sy == 0);
    end

endmodule

`default_nettype wire

// ==== line_dispatch.sv ====
// ##########################################################################
// edge dispatcher: holds the cube edge table and hands each edge, with
// its colour, to the lowest free line engine after a frame start
// ##########################################################################

`default_nettype none
`timescale 1ns/1ps

`include "cube_macros.svh"

module line_dispatch import cube_pkg::*; (
    input  wire logic                  clk_100m,
    input  wire logic                  rst,
    input  wire logic                  draw_en,
    input  wire logic                  frame,
    input  wire cidx_t                 line_cidx,
    input  wire logic [`N_ENGINES-1:0] eng_done,
    input  wire logic [`N_ENGINES-1:0] eng_busy,   // engine drawing
    output logic [`N_ENGINES-1:0]      eng_start,
    output coord_t                     eng_x0 [`N_ENGINES],
    output coord_t                     eng_y0 [`N_ENGINES],
    output coord_t                     eng_x1 [`N_ENGINES],
    output coord_t                     eng_y1 [`N_ENGINES],
    output cidx_t                      eng_cidx [`N_ENGINES],
    output logic                       draw_done
);

    localparam int LID_W = $clog2(`LINE_CNT);
    localparam int CNT_W = $clog2(`LINE_CNT + 1);

    // cube edges in 160x120 space, front face first
    localparam coord_t EDGE_X0 [`LINE_CNT] = '{ 65, 115, 115,  65,  65,  45,  45,  45,  95};
    localparam coord_t EDGE_Y0 [`LINE_CNT] = '{ 45,  45,  95,  95,  95,  75,  25,  25,  25};
    localparam coord_t EDGE_X1 [`LINE_CNT] = '{115, 115,  65,  65,  45,  45,  65,  95, 115};
    localparam coord_t EDGE_Y1 [`LINE_CNT] = '{ 45,  95,  95,  45,  75,  25,  45,  25,  45};

    dispatch_state_t state;
    logic [LID_W-1:0] line_id;         // next edge to issue
    logic [CNT_W-1:0] done_cnt;        // edges finished so far
    logic [CNT_W-1:0] done_sum;
    logic [`N_ENGINES-1:0] eng_pend;   // started, drawing not yet seen
    logic [`N_ENGINES-1:0] eng_free;
    logic [`N_ENGINES-1:0] free_oh;    // lowest free engine
    logic issue;

    always_comb begin
        eng_free = ~(eng_busy | eng_pend | eng_start);
        free_oh  = eng_free & (~eng_free + 1'b1);
        issue    = (state == ISSUE) && (|eng_free);
        done_sum = done_cnt;
        for (int i = 0; i < `N_ENGINES; i++) begin
            if (eng_done[i]) begin
                done_sum = done_sum + 1'b1;  // several may finish together
            end
        end
    end

    // per engine start strobe and edge registers
    always_ff @(posedge clk_100m) begin
        for (int i = 0; i < `N_ENGINES; i++) begin
            eng_start[i] <= issue && free_oh[i];
            if (issue && free_oh[i]) begin
                eng_x0[i]   <= EDGE_X0[line_id];
                eng_y0[i]   <= EDGE_Y0[line_id];
                eng_x1[i]   <= EDGE_X1[line_id];
                eng_y1[i]   <= EDGE_Y1[line_id];
                eng_cidx[i] <= line_cidx;
                eng_pend[i] <= 1'b1;
            end else if (eng_busy[i]) begin
                eng_pend[i] <= 1'b0;
            end
        end
        if (rst) begin
            eng_start <= '0;
            eng_pend  <= '0;
        end
    end

    always_ff @(posedge clk_100m) begin
        case (state)
            IDLE: begin
                line_id  <= '0;
                done_cnt <= '0;
                state    <= WAIT_FRAME;
            end
            WAIT_FRAME: if (frame && draw_en) state <= ISSUE;
            ISSUE: begin
                done_cnt <= done_sum;
                if (issue) begin
                    if (line_id == LID_W'(`LINE_CNT - 1)) begin
                        state <= WAIT_DONE;  // whole table handed out
                    end else begin
                        line_id <= line_id + 1'b1;
                    end
                end
            end
            WAIT_DONE: begin
                done_cnt <= done_sum;
                if (done_sum == CNT_W'(`LINE_CNT)) begin
                    state     <= FINISHED;
                    draw_done <= 1'b1;
                end
            end
            FINISHED: draw_done <= 1'b1;  // held until reset
            default: state <= IDLE;
        endcase
        if (rst) begin
            state     <= IDLE;
            line_id   <= '0;
            done_cnt  <= '0;
            draw_done <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// ==== draw_line.sv ====
// ##########################################################################
// Bresenham line engine: one pixel per accepted cycle, both end points
// included, done pulses after the last pixel is taken
// ##########################################################################

`default_nettype none
`timescale 1ns/1ps

module draw_line import cube_pkg::*; #(
    parameter int CORDW = 16
) (
    input  wire logic                    clk_100m,
    input  wire logic                    rst,
    input  wire logic                    start,
    input  wire logic                    oe,       // pixel accepted
    input  wire logic signed [CORDW-1:0] x0,
    input  wire logic signed [CORDW-1:0] y0,
    input  wire logic signed [CORDW-1:0] x1,
    input  wire logic signed [CORDW-1:0] y1,
    output logic signed [CORDW-1:0]      x,
    output logic signed [CORDW-1:0]      y,
    output logic                         drawing,
    output logic                         done
);

    line_state_t state;
    logic signed [CORDW-1:0] xe, ye;          // end point
    logic signed [CORDW:0]   dx, dy, err;     // dy kept negative
    logic signed [CORDW:0]   dx_raw, dy_raw;
    logic signed [CORDW:0]   dx_abs, dy_neg;
    logic signed [CORDW:0]   err_nxt;
    logic signed [CORDW+1:0] e2;
    logic right, down;                        // step directions
    logic step_x, step_y;
    logic last;

    // setup terms from the latched end points
    always_comb begin
        dx_raw = {xe[CORDW-1], xe} - {x[CORDW-1], x};
        dy_raw = {ye[CORDW-1], ye} - {y[CORDW-1], y};
        dx_abs = (dx_raw < 0) ? -dx_raw : dx_raw;
        dy_neg = (dy_raw < 0) ? dy_raw : -dy_raw;
    end

    always_comb begin
        e2      = {err, 1'b0};
        step_x  = (e2 >= dy);
        step_y  = (e2 <= dx);
        err_nxt = err;
        if (step_x) err_nxt = err_nxt + dy;
        if (step_y) err_nxt = err_nxt + dx;
        last    = (x == xe) && (y == ye);
        drawing = (state == L_DRAW);
    end

    always_ff @(posedge clk_100m) begin
        done <= 1'b0;
        case (state)
            L_INIT: begin
                right <= (dx_raw >= 0);
                down  <= (dy_raw >= 0);
                dx    <= dx_abs;
                dy    <= dy_neg;
                err   <= dx_abs + dy_neg;
                state <= L_DRAW;
            end
            L_DRAW: begin
                if (oe) begin  // otherwise hold the pixel
                    if (last) begin
                        state <= L_IDLE;
                        done  <= 1'b1;
                    end else begin
                        if (step_x) x <= right ? x + 1'b1 : x - 1'b1;
                        if (step_y) y <= down ? y + 1'b1 : y - 1'b1;
                        err <= err_nxt;
                    end
                end
            end
            default: begin  // L_IDLE
                if (start) begin
                    x     <= x0;
                    y     <= y0;
                    xe    <= x1;
                    ye    <= y1;
                    state <= L_INIT;
                end
            end
        endcase
        if (rst) begin
            state <= L_IDLE;
            done  <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// ==== pixel_merge.sv ====
// ##########################################################################
// pixel merger: fixed priority grant of the single framebuffer write
// port, lowest drawing engine wins, write registered
// ##########################################################################

`default_nettype none
`timescale 1ns/1ps

`include "cube_macros.svh"

module pixel_merge import cube_pkg::*; (
    input  wire logic                  clk_100m,
    input  wire logic                  rst,
    input  wire logic [`N_ENGINES-1:0] eng_drawing,
    input  wire coord_t                eng_x [`N_ENGINES],
    input  wire coord_t                eng_y [`N_ENGINES],
    input  wire cidx_t                 eng_cidx [`N_ENGINES],
    output logic [`N_ENGINES-1:0]      eng_oe,     // grant
    output logic                       fb_we,
    output coord_t                     fb_x,
    output coord_t                     fb_y,
    output cidx_t                      fb_cidx
);

    logic [`N_ENGINES-1:0] grant;
    coord_t sel_x, sel_y;
    cidx_t  sel_cidx;

    // isolate lowest set bit, then mux the granted pixel
    always_comb begin
        grant    = eng_drawing & (~eng_drawing + 1'b1);
        sel_x    = '0;
        sel_y    = '0;
        sel_cidx = '0;
        for (int i = 0; i < `N_ENGINES; i++) begin
            if (grant[i]) begin
                sel_x    = eng_x[i];
                sel_y    = eng_y[i];
                sel_cidx = eng_cidx[i];
            end
        end
        eng_oe = grant;  // others hold their pixel
    end

    always_ff @(posedge clk_100m) begin
        fb_we   <= |grant;
        fb_x    <= sel_x;
        fb_y    <= sel_y;
        fb_cidx <= sel_cidx;
        if (rst) fb_we <= 1'b0;
    end

endmodule

`default_nettype wire

// ==== framebuffer.sv ====
// ##########################################################################
// colour index framebuffer with one write port, a registered display
// read and a fixed 16 entry palette to 4-bit RGB
// ##########################################################################

`default_nettype none
`timescale 1ns/1ps

`include "cube_macros.svh"

module framebuffer import cube_pkg::*; (
    input  wire logic   clk_100m,
    input  wire logic   we,
    input  wire coord_t wx,
    input  wire coord_t wy,
    input  wire cidx_t  wcidx,
    input  wire coord_t sx,       // display scan position
    input  wire coord_t sy,
    input  wire logic   de,
    output chan_t       red,
    output chan_t       green,
    output chan_t       blue
);

    localparam int FB_PIXELS = `FB_WIDTH * `FB_HEIGHT;
    localparam int ADDRW     = $clog2(FB_PIXELS);

    // {r, g, b}: r = i, g = 15 - i, b = i >> 1, entry 0 black
    localparam logic [3*`CHANW-1:0] PALETTE [16] = '{
        12'h000, 12'h1E0, 12'h2D1, 12'h3C1, 12'h4B2, 12'h5A2, 12'h693, 12'h783,
        12'h874, 12'h964, 12'hA55, 12'hB45, 12'hC36, 12'hD26, 12'hE17, 12'hF07
    };

    cidx_t mem [FB_PIXELS];
    logic [ADDRW-1:0] waddr, raddr;
    cidx_t rd_cidx;
    logic  de_q;                      // de aligned with read data
    logic [3*`CHANW-1:0] pal_rgb;

    initial begin
        for (int i = 0; i < FB_PIXELS; i++) begin
            mem[i] = '0;  // blank screen
        end
    end

    always_comb begin
        waddr = ADDRW'(wy) * ADDRW'(`FB_WIDTH) + ADDRW'(wx);
        raddr = de ? ADDRW'(sy) * ADDRW'(`FB_WIDTH) + ADDRW'(sx) : '0;
    end

    always_ff @(posedge clk_100m) begin
        if (we) mem[waddr] <= wcidx;
        rd_cidx <= mem[raddr];
        de_q    <= de;
    end

    // palette lookup, black outside the visible area
    always_comb begin
        pal_rgb = PALETTE[rd_cidx];
        red     = de_q ? pal_rgb[3*`CHANW-1:2*`CHANW] : '0;
        green   = de_q ? pal_rgb[2*`CHANW-1:`CHANW] : '0;
        blue    = de_q ? pal_rgb[`CHANW-1:0] : '0;
    end

endmodule

`default_nettype wire

// ==== cube_render_top.sv ====
// ##########################################################################
// wireframe cube renderer: edge dispatch, line engine bank, pixel merge,
// framebuffer and VGA style scan out on one clock
// ##########################################################################

`default_nettype none
`timescale 1ns/1ps

`include "cube_macros.svh"

module cube_render_top import cube_pkg::*; (
    input  wire logic  clk_100m,
    input  wire logic  rst,
    input  wire logic  draw_en,
    input  wire cidx_t line_cidx,
    output logic       vga_hsync,
    output logic       vga_vsync,
    output chan_t      vga_r,
    output chan_t      vga_g,
    output chan_t      vga_b,
    output logic       draw_done
);

    coord_t sx, sy;
    logic   de, hsync, vsync, frame;
    logic   hsync_p1, vsync_p1;

    logic [`N_ENGINES-1:0] eng_start, eng_drawing, eng_done, eng_oe;
    coord_t eng_x0 [`N_ENGINES];
    coord_t eng_y0 [`N_ENGINES];
    coord_t eng_x1 [`N_ENGINES];
    coord_t eng_y1 [`N_ENGINES];
    coord_t eng_x [`N_ENGINES];
    coord_t eng_y [`N_ENGINES];
    cidx_t  eng_cidx [`N_ENGINES];

    logic   fb_we;
    coord_t fb_x, fb_y;
    cidx_t  fb_cidx;
    chan_t  fb_red, fb_green, fb_blue;

    display_timings timing_inst (
        .clk_100m, .rst, .sx, .sy, .de, .hsync, .vsync, .frame
    );

    line_dispatch dispatch_inst (
        .clk_100m, .rst, .draw_en, .frame, .line_cidx,
        .eng_done, .eng_busy(eng_drawing), .eng_start,
        .eng_x0, .eng_y0, .eng_x1, .eng_y1, .eng_cidx, .draw_done
    );

    for (genvar i = 0; i < `N_ENGINES; i++) begin : eng_g
        draw_line #(.CORDW(`CORDW)) line_inst (
            .clk_100m, .rst,
            .start(eng_start[i]), .oe(eng_oe[i]),
            .x0(eng_x0[i]), .y0(eng_y0[i]), .x1(eng_x1[i]), .y1(eng_y1[i]),
            .x(eng_x[i]), .y(eng_y[i]),
            .drawing(eng_drawing[i]), .done(eng_done[i])
        );
    end

    pixel_merge merge_inst (
        .clk_100m, .rst, .eng_drawing, .eng_x, .eng_y, .eng_cidx,
        .eng_oe, .fb_we, .fb_x, .fb_y, .fb_cidx
    );

    framebuffer fb_inst (
        .clk_100m, .we(fb_we), .wx(fb_x), .wy(fb_y), .wcidx(fb_cidx),
        .sx, .sy, .de, .red(fb_red), .green(fb_green), .blue(fb_blue)
    );

    // fb read plus output register is two cycles, syncs follow
    always_ff @(posedge clk_100m) begin
        hsync_p1  <= hsync;
        vsync_p1  <= vsync;
        vga_hsync <= hsync_p1;
        vga_vsync <= vsync_p1;
        vga_r     <= fb_red;
        vga_g     <= fb_green;
        vga_b     <= fb_blue;
        if (rst) begin
            hsync_p1  <= 1'b0;
            vsync_p1  <= 1'b0;
            vga_hsync <= 1'b0;
            vga_vsync <= 1'b0;
            vga_r     <= '0;
            vga_g     <= '0;
            vga_b     <= '0;
        end
    end

endmodule

`default_nettype wire

// ==== cube_render_asserts.sv ====
// ##########################################################################
// concurrent checks on the pixel merger grants and framebuffer write port
// ##########################################################################

`default_nettype none
`timescale 1ns/1ps

`include "cube_macros.svh"

module cube_render_asserts import cube_pkg::*; (
    input wire logic                  clk_100m,
    input wire logic                  rst,
    input wire logic [`N_ENGINES-1:0] eng_drawing,
    input wire logic [`N_ENGINES-1:0] eng_oe,
    input wire logic                  fb_we,
    input wire coord_t                fb_x,
    input wire coord_t                fb_y
);

    a_single_grant: assert property (@(posedge clk_100m) disable iff (rst)
        $onehot0(eng_oe))
        else $error("more than one engine granted in one cycle");

    // grant only to an engine with a pixel
    a_grant_drawing: assert property (@(posedge clk_100m) disable iff (rst)
        (eng_oe & ~eng_drawing) == '0)
        else $error("grant given to an idle engine");

    a_write_in_range: assert property (@(posedge clk_100m) disable iff (rst)
        fb_we |-> (fb_x >= 0 && fb_x < `FB_WIDTH && fb_y >= 0 && fb_y < `FB_HEIGHT))
        else $error("framebuffer write outside the picture");

endmodule

bind pixel_merge cube_render_asserts merge_chk (
    .clk_100m, .rst, .eng_drawing, .eng_oe, .fb_we, .fb_x, .fb_y
);

`default_nettype wire

// ==== cube_render_tb.sv ====
// ##########################################################################
// cube renderer testbench checking blank frames, sync timing and the drawn
// cube pixel by pixel against a Bresenham reference on the VGA scan
// ##########################################################################

`default_nettype none
`timescale 1ns/1ps

`include "cube_macros.svh"

module cube_render_tb
    import cube_pkg::*;
();

    localparam int H_TOTAL      = `FB_WIDTH + `H_FRONT + `H_SYNC + `H_BACK;
    localparam int V_TOTAL      = `FB_HEIGHT + `V_FRONT + `V_SYNC + `V_BACK;
    localparam int H_SYNC_START = `FB_WIDTH + `H_FRONT;
    localparam int V_SYNC_START = `FB_HEIGHT + `V_FRONT;
    localparam int FRAME_CYCLES = H_TOTAL * V_TOTAL;
    localparam int FB_PIXELS    = `FB_WIDTH * `FB_HEIGHT;

    localparam int MODE_SKIP  = 0;  // frame not compared
    localparam int MODE_BLACK = 1;
    localparam int MODE_CUBE  = 2;

    // cube edges as x0, y0, x1, y1
    localparam int EDGES [`LINE_CNT][4] = '{
        '{65, 45, 115, 45}, '{115, 45, 115, 95}, '{115, 95, 65, 95},
        '{65, 95, 65, 45},  '{65, 95, 45, 75},   '{45, 75, 45, 25},
        '{45, 25, 65, 45},  '{45, 25, 95, 25},   '{95, 25, 115, 45}
    };

    logic  clk_100m;
    logic  rst;
    logic  draw_en;
    cidx_t line_cidx;
    logic  vga_hsync;
    logic  vga_vsync;
    chan_t vga_r, vga_g, vga_b;
    logic  draw_done;

    logic [15:0] lfsr;
    cidx_t cube_cidx;
    bit    on_edge [`FB_HEIGHT][`FB_WIDTH];  // reference picture
    int    mode, frame_mode;
    int    frames_checked;                   // fully compared frames
    int    pix_cnt;
    int    base;

    // scan position recovered from the syncs
    logic  hs_q, vs_q;
    bit    h_lock, v_lock;
    int    hpos, vpos, nh, nv;
    int    h_cnt, h_hi, v_cnt, v_hi;
    chan_t exp_r, exp_g, exp_b;

    cube_render_top dut0 (.*);

    initial clk_100m = 1'b0;
    always #5 clk_100m = ~clk_100m;

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic int rand_bits(int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            v = (v << 1) | int'(lfsr[15]);
            lfsr = lfsr_next(lfsr);  // one step per bit
        end
        return v;
    endfunction

    function automatic void palette_rgb(input cidx_t i, output chan_t r, g, b);
        if (i == 0) begin
            r = '0;
            g = '0;
            b = '0;
        end else begin
            r = chan_t'(i);
            g = chan_t'(15 - int'(i));
            b = chan_t'(i >> 1);
        end
    endfunction

    // plain Bresenham marking both end points
    function automatic void trace_line(int x0, int y0, int x1, int y1);
        int dx, dy, err, e2, step_x, step_y, x, y;
        dx     = (x1 > x0) ? x1 - x0 : x0 - x1;
        dy     = (y1 > y0) ? y0 - y1 : y1 - y0;  // kept negative
        step_x = (x1 >= x0) ? 1 : -1;
        step_y = (y1 >= y0) ? 1 : -1;
        err    = dx + dy;
        x      = x0;
        y      = y0;
        while (1) begin
            on_edge[y][x] = 1'b1;
            if (x == x1 && y == y1) break;
            e2 = 2 * err;
            if (e2 >= dy) begin
                err += dy;
                x   += step_x;
            end
            if (e2 <= dx) begin
                err += dx;
                y   += step_y;
            end
        end
    endfunction

    function automatic void ref_pixel(input int x, input int y, output chan_t r, g, b);
        if (on_edge[y][x]) begin
            palette_rgb(cube_cidx, r, g, b);
        end else begin
            palette_rgb('0, r, g, b);
        end
    endfunction

    task automatic abort_run();
        $display("FAIL: see errors above");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_rgb(input chan_t got_r, got_g, got_b, exp_r, exp_g, exp_b,
                             input string what);
        if ({got_r, got_g, got_b} !== {exp_r, exp_g, exp_b}) begin
            $display("CHECK FAILED time %0t: %s rgb %h/%h/%h, expected %h/%h/%h",
                     $time, what, got_r, got_g, got_b, exp_r, exp_g, exp_b);
            abort_run();
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("CHECK FAILED time %0t: %s is %b, expected %b", $time, what, got, exp);
            abort_run();
        end
    endtask

    task automatic check_count(input int got, input int exp, input string what);
        if (got != exp) begin
            $display("CHECK FAILED time %0t: %s is %0d, expected %0d", $time, what, got, exp);
            abort_run();
        end
    endtask

    task automatic wait_frames(input int target, input string what);
        int cycles;
        cycles = 0;
        while (frames_checked < target) begin
            @(negedge clk_100m);
            cycles++;
            if (cycles > 4 * FRAME_CYCLES) begin
                $display("ERROR: timed out after %0d cycles waiting for %s", cycles, what);
                abort_run();
            end
        end
    endtask

    task automatic wait_draw_done();
        int cycles;
        cycles = 0;
        while (draw_done !== 1'b1) begin
            @(negedge clk_100m);
            cycles++;
            if (cycles > 3 * FRAME_CYCLES) begin
                $display("ERROR: draw_done did not rise within three frames");
                abort_run();
            end
        end
    endtask

    // follow the syncs, check their timing and every scanned pixel
    always @(negedge clk_100m) begin
        if (!rst) begin
            h_cnt++;
            v_cnt++;
            if (vga_hsync && !hs_q) begin
                if (h_lock) check_count(h_cnt, H_TOTAL, "line period");
                h_cnt  = 0;
                h_hi   = 0;
                h_lock = 1'b1;
                nh     = H_SYNC_START;
            end else begin
                nh = (hpos + 1) % H_TOTAL;
            end
            if (vga_hsync) h_hi++;
            if (!vga_hsync && hs_q && h_lock) check_count(h_hi, `H_SYNC, "hsync width");

            if (vga_vsync && !vs_q) begin
                if (v_lock) check_count(v_cnt, FRAME_CYCLES, "frame period");
                if (h_lock) check_count(nh, 0, "vsync start column");
                v_cnt  = 0;
                v_hi   = 0;
                v_lock = 1'b1;
                nv     = V_SYNC_START;
            end else begin
                nv = (nh == 0) ? (vpos + 1) % V_TOTAL : vpos;
            end
            if (vga_vsync) v_hi++;
            if (!vga_vsync && vs_q && v_lock) begin
                check_count(v_hi, `V_SYNC * H_TOTAL, "vsync width");
            end
            hpos = nh;
            vpos = nv;
            hs_q = vga_hsync;
            vs_q = vga_vsync;

            if (h_lock && v_lock) begin
                if (hpos == 0 && vpos == 0) begin
                    frame_mode = mode;  // takes effect on a frame boundary
                    pix_cnt    = 0;
                end
                if (hpos < `FB_WIDTH && vpos < `FB_HEIGHT) begin
                    if (frame_mode != MODE_SKIP) begin
                        if (frame_mode == MODE_CUBE) begin
                            ref_pixel(hpos, vpos, exp_r, exp_g, exp_b);
                        end else begin
                            palette_rgb('0, exp_r, exp_g, exp_b);
                        end
                        check_rgb(vga_r, vga_g, vga_b, exp_r, exp_g, exp_b,
                                  $sformatf("pixel %0d,%0d", hpos, vpos));
                        pix_cnt++;
                        if (pix_cnt == FB_PIXELS) frames_checked++;
                    end
                end else begin
                    check_rgb(vga_r, vga_g, vga_b, '0, '0, '0, "blanking");
                end
                if (frame_mode == MODE_BLACK) check_flag(draw_done, 1'b0, "draw_done");
            end
        end
    end

    initial begin
        rst            = 1'b1;
        draw_en        = 1'b0;
        line_cidx      = '0;
        lfsr           = 16'd7164;
        mode           = MODE_BLACK;
        frame_mode     = MODE_SKIP;
        frames_checked = 0;
        pix_cnt        = 0;
        hs_q           = 1'b0;
        vs_q           = 1'b0;
        hpos           = 0;
        vpos           = 0;
        h_cnt          = 0;
        v_cnt          = 0;
        h_hi           = 0;
        v_hi           = 0;

        repeat (16) @(posedge clk_100m);
        #1 rst = 1'b0;

        // outputs straight after reset
        @(negedge clk_100m);
        check_flag(vga_hsync, 1'b0, "vga_hsync after reset");
        check_flag(vga_vsync, 1'b0, "vga_vsync after reset");
        check_flag(draw_done, 1'b0, "draw_done after reset");
        check_rgb(vga_r, vga_g, vga_b, '0, '0, '0, "rgb after reset");

        // two blank frames with drawing off
        wait_frames(2, "two blank frames");

        cube_cidx = cidx_t'(rand_bits(`CIDXW));
        if (cube_cidx == 0) cube_cidx = 1;  // black would hide the cube
        for (int i = 0; i < `LINE_CNT; i++) begin
            trace_line(EDGES[i][0], EDGES[i][1], EDGES[i][2], EDGES[i][3]);
        end

        @(posedge clk_100m);
        #1;
        mode      = MODE_SKIP;  // picture changes while drawing
        line_cidx = cube_cidx;
        draw_en   = 1'b1;
        wait_draw_done();

        mode = MODE_CUBE;
        base = frames_checked;
        wait_frames(base + 1, "a full cube frame");
        check_flag(draw_done, 1'b1, "draw_done after the cube frame");

        $display("PASS: all tests");
        $finish;
    end

endmodule

`default_nettype wire

// ==== src.f ====
+incdir+.
cube_pkg.sv
display_timings.sv
line_dispatch.sv
draw_line.sv
pixel_merge.sv
framebuffer.sv
cube_render_top.sv
cube_render_asserts.sv
cube_render_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the cube renderer testbench with Verilator, run it, decide on the log
rm -rf obj_dir sim.log
verilator --binary --assert -Wno-fatal --top-module cube_render_tb -f src.f \
    -o cube_render_sim \
    && ./obj_dir/cube_render_sim 2>&1 | tee sim.log \
    || echo "build or simulation ended with an error"
grep -qx "PASS: all tests" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed, see sim.log"; exit 1; }
